// File: regs_pkg.sv
`default_nettype none

package regs_pkg;

    typedef logic [31:0] word_t;
    // unified register address, gpr / cp0 / hi-lo in one space
    typedef logic [6:0] reg_addr_t;

    typedef enum logic [1:0] {
        KIND_GPR,
        KIND_CP0,
        KIND_HILO,
        KIND_BAD
    } reg_kind_e;

    localparam reg_addr_t ADDR_LO = 7'd64;
    localparam reg_addr_t ADDR_HI = 7'd127;

    // cp0 register indices
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // status: ie, exl, im[15:8]
    localparam word_t STATUS_WMASK = 32'h0000_ff03;
    // cause: software interrupt bits only
    localparam word_t CAUSE_WMASK  = 32'h0000_0300;

    function automatic reg_kind_e addr_kind(input reg_addr_t addr);
        reg_kind_e kind;
        if (addr[6]) begin
            // only 64 and 127 are populated above the cp0 window
            kind = (addr == ADDR_LO || addr == ADDR_HI) ? KIND_HILO : KIND_BAD;
        end else if (addr[5]) begin
            kind = KIND_CP0;
        end else begin
            kind = KIND_GPR;
        end
        return kind;
    endfunction

endpackage

`default_nettype wire

// File: reg_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_wr_if;

    // single-word write
    logic                en;
    regs_pkg::reg_addr_t addr;
    regs_pkg::word_t     data;

    // full hi/lo write, {hi, lo}
    logic                hl_en;
    logic [63:0]         hl_data;

    // arbiter side
    modport source (
        output en,
        output addr,
        output data,
        output hl_en,
        output hl_data
    );

    // register storage side
    modport sink (
        input en,
        input addr,
        input data,
        input hl_en,
        input hl_data
    );

endinterface

`default_nettype wire

// File: gpr_hilo_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_hilo_file (
    input  wire                       clk,
    input  wire                       rst,
    reg_wr_if.sink                    wr,
    input  wire regs_pkg::reg_addr_t  rd_addr_1,
    input  wire regs_pkg::reg_addr_t  rd_addr_2,
    output regs_pkg::word_t           rd_data_1,
    output regs_pkg::word_t           rd_data_2,
    input  wire regs_pkg::reg_addr_t  dbg_addr,
    output regs_pkg::word_t           dbg_data,
    input  wire regs_pkg::word_t      cp0_data_2,
    input  wire regs_pkg::word_t      cp0_data_dbg
);

    regs_pkg::word_t     gpr [0:31];
    regs_pkg::word_t     hi_r;
    regs_pkg::word_t     lo_r;

    // local copies of the write bus for the read function
    logic                bus_en;
    regs_pkg::reg_addr_t bus_addr;
    regs_pkg::word_t     bus_data;
    logic                bus_hl_en;
    logic [63:0]         bus_hl_data;

    logic                gpr_we;

    assign bus_en      = wr.en;
    assign bus_addr    = wr.addr;
    assign bus_data    = wr.data;
    assign bus_hl_en   = wr.hl_en;
    assign bus_hl_data = wr.hl_data;

    // register 0 is never written
    assign gpr_we = bus_en
                 && (regs_pkg::addr_kind(bus_addr) == regs_pkg::KIND_GPR)
                 && (bus_addr[4:0] != 5'd0);

    // general registers, no reset
    always_ff @(posedge clk) begin
        if (gpr_we) begin
            gpr[bus_addr[4:0]] <= bus_data;
        end
    end

    // hi/lo, 64-bit write wins over single-word write
    always_ff @(posedge clk) begin
        if (rst) begin
            hi_r <= '0;
            lo_r <= '0;
        end else if (bus_hl_en) begin
            hi_r <= bus_hl_data[63:32];
            lo_r <= bus_hl_data[31:0];
        end else if (bus_en) begin
            if (bus_addr == regs_pkg::ADDR_HI) begin
                hi_r <= bus_data;
            end
            if (bus_addr == regs_pkg::ADDR_LO) begin
                lo_r <= bus_data;
            end
        end
    end

    // one read port, bypass then storage
    // cp0_in is the cp0 read data for this port, zero where there is none
    function automatic regs_pkg::word_t read_port(
        input regs_pkg::reg_addr_t addr,
        input regs_pkg::word_t     cp0_in
    );
        regs_pkg::word_t res;
        if (addr == '0) begin
            res = '0;
        end else if (bus_en && (bus_addr == addr)) begin
            // same-cycle write forward
            res = bus_data;
        end else if (bus_hl_en && (regs_pkg::addr_kind(addr) == regs_pkg::KIND_HILO)) begin
            res = (addr == regs_pkg::ADDR_HI) ? bus_hl_data[63:32] : bus_hl_data[31:0];
        end else begin
            case (regs_pkg::addr_kind(addr))
                regs_pkg::KIND_GPR:  res = gpr[addr[4:0]];
                regs_pkg::KIND_HILO: res = (addr == regs_pkg::ADDR_HI) ? hi_r : lo_r;
                regs_pkg::KIND_CP0:  res = cp0_in;
                default:             res = '0;
            endcase
        end
        return res;
    endfunction

    always_comb begin
        // port 1 has no cp0 path
        rd_data_1 = read_port(rd_addr_1, '0);
        rd_data_2 = read_port(rd_addr_2, cp0_data_2);
        dbg_data  = read_port(dbg_addr, cp0_data_dbg);
    end

endmodule

`default_nettype wire

// File: cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire                   clk,
    input  wire                   rst,
    reg_wr_if.sink                wr,
    input  wire [4:0]             rd_idx_2,
    input  wire [4:0]             rd_idx_dbg,
    output regs_pkg::word_t       rd_data_2,
    output regs_pkg::word_t       rd_data_dbg,
    input  wire                   exc_valid,
    input  wire [4:0]             exc_code,
    input  wire regs_pkg::word_t  exc_epc,
    input  wire regs_pkg::word_t  exc_badvaddr,
    input  wire                   exc_bd,
    input  wire                   eret,
    input  wire [5:0]             hw_int,
    output regs_pkg::word_t       status,
    output regs_pkg::word_t       cause,
    output regs_pkg::word_t       epc,
    output logic                  irq_pending
);

    regs_pkg::word_t status_r;
    regs_pkg::word_t cause_r;
    regs_pkg::word_t epc_r;
    regs_pkg::word_t badvaddr_r;

    logic            mtc0;

    assign mtc0 = wr.en && (regs_pkg::addr_kind(wr.addr) == regs_pkg::KIND_CP0);

    always_ff @(posedge clk) begin
        if (rst) begin
            status_r   <= '0;
            cause_r    <= '0;
            epc_r      <= '0;
            badvaddr_r <= '0;
        end else begin
            if (exc_valid) begin
                // nested exception only updates the code
                cause_r[6:2] <= exc_code;
                if (!status_r[1]) begin
                    status_r[1]  <= 1'b1;
                    cause_r[31]  <= exc_bd;
                    epc_r        <= exc_epc;
                    badvaddr_r   <= exc_badvaddr;
                end
            end else begin
                if (mtc0) begin
                    case (wr.addr[4:0])
                        regs_pkg::CP0_STATUS: status_r <=
                            (status_r & ~regs_pkg::STATUS_WMASK)
                            | (wr.data & regs_pkg::STATUS_WMASK);
                        regs_pkg::CP0_CAUSE: cause_r <=
                            (cause_r & ~regs_pkg::CAUSE_WMASK)
                            | (wr.data & regs_pkg::CAUSE_WMASK);
                        regs_pkg::CP0_EPC: epc_r <= wr.data;
                        // badvaddr is read-only
                        default: ;
                    endcase
                end
                // eret last, so it wins the exl bit
                if (eret) begin
                    status_r[1] <= 1'b0;
                end
            end
            // hardware interrupt lines sampled every cycle
            cause_r[15:10] <= hw_int;
        end
    end

    function automatic regs_pkg::word_t cp0_read(input logic [4:0] idx);
        regs_pkg::word_t res;
        case (idx)
            regs_pkg::CP0_BADVADDR: res = badvaddr_r;
            regs_pkg::CP0_STATUS:   res = status_r;
            regs_pkg::CP0_CAUSE:    res = cause_r;
            regs_pkg::CP0_EPC:      res = epc_r;
            default:                res = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        rd_data_2   = cp0_read(rd_idx_2);
        rd_data_dbg = cp0_read(rd_idx_dbg);
    end

    assign status = status_r;
    assign cause  = cause_r;
    assign epc    = epc_r;

    // ie, not exl, and any pending line unmasked by im
    assign irq_pending = status_r[0] & ~status_r[1] & (|(cause_r[15:8] & status_r[15:8]));

endmodule

`default_nettype wire

// File: debug_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

module debug_apb_port (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [8:0]                 paddr,
    input  wire regs_pkg::word_t      pwdata,
    output regs_pkg::word_t           prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      req,
    output regs_pkg::reg_addr_t       req_addr,
    output regs_pkg::word_t           req_data,
    input  wire                       gnt,
    output regs_pkg::reg_addr_t       rd_addr,
    input  wire regs_pkg::word_t      rd_data
);

    regs_pkg::reg_addr_t reg_addr;
    logic                bad;
    logic                access;
    logic                done;

    // word address from byte address
    assign reg_addr = paddr[8:2];
    assign bad      = (regs_pkg::addr_kind(reg_addr) == regs_pkg::KIND_BAD);

    // access phase not yet completed
    assign access = psel & penable & ~done;

    // bad addresses never reach the arbiter
    assign req      = access & pwrite & ~bad;
    assign req_addr = reg_addr;
    assign req_data = pwdata;

    // reads and errors finish at once, writes wait for the grant
    assign pready  = access & (~pwrite | bad | gnt);
    assign pslverr = access & bad;

    assign rd_addr = reg_addr;
    assign prdata  = (access & ~pwrite & ~bad) ? rd_data : '0;

    // held until the master leaves the access phase
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (!psel || !penable) begin
            done <= 1'b0;
        end else if (pready) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: reg_wr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module reg_wr_arbiter (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       wb_en,
    input  wire regs_pkg::reg_addr_t  wb_addr,
    input  wire regs_pkg::word_t      wb_data,
    input  wire                       wb_hl_en,
    input  wire [63:0]                wb_hl_data,
    input  wire                       dbg_req,
    input  wire regs_pkg::reg_addr_t  dbg_addr,
    input  wire regs_pkg::word_t      dbg_data,
    output logic                      dbg_gnt,
    reg_wr_if.source                  bus
);

    logic       wb_busy;

    // write-back has no back-pressure, always first
    assign wb_busy = wb_en | wb_hl_en;
    assign dbg_gnt = dbg_req & ~wb_busy;

    assign bus.en      = wb_busy ? wb_en : dbg_req;
    assign bus.addr    = wb_busy ? wb_addr : dbg_addr;
    assign bus.data    = wb_busy ? wb_data : dbg_data;
    // debug never drives a hi/lo pair write
    assign bus.hl_en   = wb_hl_en;
    assign bus.hl_data = wb_hl_data;

endmodule

`default_nettype wire

// File: reg_state_top.sv
`timescale 1ns/1ps
`default_nettype none

module reg_state_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       wb_en,
    input  wire regs_pkg::reg_addr_t  wb_addr,
    input  wire regs_pkg::word_t      wb_data,
    input  wire                       wb_hl_en,
    input  wire [63:0]                wb_hl_data,
    input  wire regs_pkg::reg_addr_t  rd_addr_1,
    input  wire regs_pkg::reg_addr_t  rd_addr_2,
    output regs_pkg::word_t           rd_data_1,
    output regs_pkg::word_t           rd_data_2,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [8:0]                 paddr,
    input  wire regs_pkg::word_t      pwdata,
    output regs_pkg::word_t           prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  wire                       exc_valid,
    input  wire [4:0]                 exc_code,
    input  wire regs_pkg::word_t      exc_epc,
    input  wire regs_pkg::word_t      exc_badvaddr,
    input  wire                       exc_bd,
    input  wire                       eret,
    input  wire [5:0]                 hw_int,
    output regs_pkg::word_t           status,
    output regs_pkg::word_t           cause,
    output regs_pkg::word_t           epc,
    output logic                      irq_pending
);

    reg_wr_if wr_bus ();

    logic                dbg_req;
    regs_pkg::reg_addr_t dbg_req_addr;
    regs_pkg::word_t     dbg_req_data;
    logic                dbg_gnt;
    regs_pkg::reg_addr_t dbg_rd_addr;
    regs_pkg::word_t     dbg_rd_data;
    regs_pkg::word_t     cp0_rd_data_2;
    regs_pkg::word_t     cp0_rd_data_dbg;

    reg_wr_arbiter u_arb (
        .clk(clk), .rst(rst),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .wb_hl_en(wb_hl_en), .wb_hl_data(wb_hl_data),
        .dbg_req(dbg_req), .dbg_addr(dbg_req_addr), .dbg_data(dbg_req_data),
        .dbg_gnt(dbg_gnt), .bus(wr_bus.source)
    );

    debug_apb_port u_dbg (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .req(dbg_req), .req_addr(dbg_req_addr), .req_data(dbg_req_data), .gnt(dbg_gnt),
        .rd_addr(dbg_rd_addr), .rd_data(dbg_rd_data)
    );

    gpr_hilo_file u_gpr (
        .clk(clk), .rst(rst), .wr(wr_bus.sink),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .dbg_addr(dbg_rd_addr), .dbg_data(dbg_rd_data),
        .cp0_data_2(cp0_rd_data_2), .cp0_data_dbg(cp0_rd_data_dbg)
    );

    // cp0 index is the low five address bits
    cp0_regs u_cp0 (
        .clk(clk), .rst(rst), .wr(wr_bus.sink),
        .rd_idx_2(rd_addr_2[4:0]), .rd_idx_dbg(dbg_rd_addr[4:0]),
        .rd_data_2(cp0_rd_data_2), .rd_data_dbg(cp0_rd_data_dbg),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_epc(exc_epc),
        .exc_badvaddr(exc_badvaddr), .exc_bd(exc_bd), .eret(eret), .hw_int(hw_int),
        .status(status), .cause(cause), .epc(epc), .irq_pending(irq_pending)
    );

endmodule

`default_nettype wire

// File: tb_reg_state_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reg_state_top;

    // whole sequence runs under 500 cycles
    localparam int MAX_CYCLES = 4000;

    logic clk = 1'b0;
    logic rst = 1'b1;

    logic                wb_en;
    regs_pkg::reg_addr_t wb_addr;
    regs_pkg::word_t     wb_data;
    logic                wb_hl_en;
    logic [63:0]         wb_hl_data;
    regs_pkg::reg_addr_t rd_addr_1;
    regs_pkg::reg_addr_t rd_addr_2;
    regs_pkg::word_t     rd_data_1;
    regs_pkg::word_t     rd_data_2;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [8:0]          paddr;
    regs_pkg::word_t     pwdata;
    regs_pkg::word_t     prdata;
    logic                pready;
    logic                pslverr;
    logic                exc_valid;
    logic [4:0]          exc_code;
    regs_pkg::word_t     exc_epc;
    regs_pkg::word_t     exc_badvaddr;
    logic                exc_bd;
    logic                eret;
    logic [5:0]          hw_int;
    regs_pkg::word_t     status;
    regs_pkg::word_t     cause;
    regs_pkg::word_t     epc;
    logic                irq_pending;

    // shadow copy of the architectural state
    regs_pkg::word_t gpr_m [0:31];
    regs_pkg::word_t hi_m;
    regs_pkg::word_t lo_m;
    regs_pkg::word_t status_m;
    regs_pkg::word_t cause_m;
    regs_pkg::word_t epc_m;
    regs_pkg::word_t badv_m;

    int seed = 34;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    // expected write bus, write-back before debug
    logic                m_wb_busy;
    logic                m_dbg_req;
    logic                m_en;
    regs_pkg::reg_addr_t m_addr;
    regs_pkg::word_t     m_data;

    always #2 clk = ~clk;

    reg_state_top i_dut (.*);

    // 65..126 hold nothing
    function automatic logic is_unmapped(input regs_pkg::reg_addr_t a);
        return a[6] && (a != 7'd64) && (a != 7'd127);
    endfunction

    assign m_wb_busy = wb_en | wb_hl_en;
    assign m_dbg_req = psel & penable & pwrite & ~is_unmapped(paddr[8:2]);
    assign m_en      = m_wb_busy ? wb_en : m_dbg_req;
    assign m_addr    = m_wb_busy ? wb_addr : paddr[8:2];
    assign m_data    = m_wb_busy ? wb_data : pwdata;

    function automatic regs_pkg::word_t cp0_model(input logic [4:0] idx);
        case (idx)
            5'd8:    return badv_m;
            5'd12:   return status_m;
            5'd13:   return cause_m;
            5'd14:   return epc_m;
            default: return '0;
        endcase
    endfunction

    // expected read value, bypass order first
    function automatic regs_pkg::word_t exp_read(input regs_pkg::reg_addr_t a,
                                                 input logic cp0_path);
        regs_pkg::word_t v;
        if (a == 7'd0) begin
            v = '0;
        end else if (m_en && (m_addr == a)) begin
            v = m_data;
        end else if (wb_hl_en && (a == 7'd64 || a == 7'd127)) begin
            v = (a == 7'd127) ? wb_hl_data[63:32] : wb_hl_data[31:0];
        end else if (a < 7'd32) begin
            v = gpr_m[a[4:0]];
        end else if (a < 7'd64) begin
            // port 1 sees no cp0
            v = cp0_path ? cp0_model(a[4:0]) : '0;
        end else begin
            v = (a == 7'd64) ? lo_m : ((a == 7'd127) ? hi_m : '0);
        end
        return v;
    endfunction

    function automatic logic exp_irq();
        return status_m[0] & ~status_m[1] & (|(cause_m[15:8] & status_m[15:8]));
    endfunction

    task automatic check_word(input string name, input regs_pkg::word_t got,
                              input regs_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input logic got_rdy, input logic got_err,
                              input logic exp_rdy, input logic exp_err);
        checks++;
        if ({got_rdy, got_err} !== {exp_rdy, exp_err}) begin
            errors++;
            $display("CHECK FAILED pready/pslverr: got %h/%h expected %h/%h",
                     got_rdy, got_err, exp_rdy, exp_err);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED irq_pending: got %h expected %h", got, exp);
        end
    endtask

    // model follows the same inputs the dut samples at this edge
    always @(posedge clk) begin
        if (rst) begin
            hi_m = '0;
            lo_m = '0;
            status_m = '0;
            cause_m = '0;
            epc_m = '0;
            badv_m = '0;
        end else begin
            if (m_en && (m_addr < 7'd32) && (m_addr != 7'd0)) begin
                gpr_m[m_addr[4:0]] = m_data;
            end
            if (wb_hl_en) begin
                hi_m = wb_hl_data[63:32];
                lo_m = wb_hl_data[31:0];
            end else if (m_en && (m_addr == 7'd127)) begin
                hi_m = m_data;
            end else if (m_en && (m_addr == 7'd64)) begin
                lo_m = m_data;
            end
            if (exc_valid) begin
                cause_m[6:2] = exc_code;
                // first level only, nested keeps exl, bd, epc, badvaddr
                if (!status_m[1]) begin
                    status_m[1] = 1'b1;
                    cause_m[31] = exc_bd;
                    epc_m = exc_epc;
                    badv_m = exc_badvaddr;
                end
            end else begin
                if (m_en && (m_addr[6:5] == 2'b01)) begin
                    case (m_addr[4:0])
                        5'd12: status_m = (status_m & ~32'h0000_ff03) | (m_data & 32'h0000_ff03);
                        5'd13: cause_m = (cause_m & ~32'h0000_0300) | (m_data & 32'h0000_0300);
                        5'd14: epc_m = m_data;
                        default: ;
                    endcase
                end
                if (eret) begin
                    status_m[1] = 1'b0;
                end
            end
            cause_m[15:10] = hw_int;
        end
    end

    // all combinational outputs compared mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            check_word("rd_data_1", rd_data_1, exp_read(rd_addr_1, 1'b0));
            check_word("rd_data_2", rd_data_2, exp_read(rd_addr_2, 1'b1));
            check_word("status", status, status_m);
            check_word("cause", cause, cause_m);
            check_word("epc", epc, epc_m);
            check_irq(irq_pending, exp_irq());
            // no response outside the access phase
            if (!penable) begin
                check_resp(pready, pslverr, 1'b0, 1'b0);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic wb_write(input regs_pkg::reg_addr_t a, input regs_pkg::word_t d);
        @(posedge clk);
        wb_en <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
        wb_hl_en <= 1'b0;
    endtask

    task automatic wb_hilo(input logic [63:0] d);
        @(posedge clk);
        wb_en <= 1'b0;
        wb_hl_en <= 1'b1;
        wb_hl_data <= d;
    endtask

    task automatic wb_idle();
        @(posedge clk);
        wb_en <= 1'b0;
        wb_hl_en <= 1'b0;
    endtask

    // setup, then access until pready
    task automatic apb_transfer(input logic wr, input regs_pkg::reg_addr_t a,
                                input regs_pkg::word_t d);
        logic err;
        err = is_unmapped(a);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= {a, 2'b00};
        pwdata <= d;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(negedge clk);
            // writes stall while write-back holds the bus
            check_resp(pready, pslverr, err | ~wr | ~m_wb_busy, err);
            if (!wr && pready) begin
                check_word("prdata", prdata, err ? '0 : exp_read(a, 1'b1));
            end
        end while (!pready);
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic exc_pulse(input logic [4:0] code, input regs_pkg::word_t pc,
                             input regs_pkg::word_t badv, input logic bd);
        @(posedge clk);
        exc_valid <= 1'b1;
        exc_code <= code;
        exc_epc <= pc;
        exc_badvaddr <= badv;
        exc_bd <= bd;
        @(posedge clk);
        exc_valid <= 1'b0;
    endtask

    task automatic eret_pulse();
        @(posedge clk);
        eret <= 1'b1;
        @(posedge clk);
        eret <= 1'b0;
    endtask

    function automatic regs_pkg::reg_addr_t pick_wb_addr(input logic [7:0] b);
        return (b[7:6] == 2'b11) ? (b[0] ? 7'd127 : 7'd64) : {2'b00, b[4:0]};
    endfunction

    // also hits the cp0 window
    function automatic regs_pkg::reg_addr_t pick_rd_addr(input logic [7:0] b);
        return (b[7:6] == 2'b11) ? (b[0] ? 7'd127 : 7'd64) : {1'b0, b[5:0]};
    endfunction

    initial begin
        logic [31:0] r;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        wb_hl_en = 1'b0;
        wb_hl_data = '0;
        rd_addr_1 = '0;
        rd_addr_2 = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        exc_valid = 1'b0;
        exc_code = '0;
        exc_epc = '0;
        exc_badvaddr = '0;
        exc_bd = 1'b0;
        eret = 1'b0;
        hw_int = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // gprs have no reset, fill them first
        for (int i = 1; i < 32; i++) begin
            wb_write(i[6:0], $random(seed));
        end
        // random write-back, reads often hit the address in flight
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            @(posedge clk);
            wb_en <= r[0];
            wb_addr <= pick_wb_addr(r[15:8]);
            wb_data <= $random(seed);
            wb_hl_en <= (r[3:1] == 3'd0);
            wb_hl_data <= {$random(seed), $random(seed)};
            rd_addr_1 <= r[4] ? pick_wb_addr(r[15:8]) : pick_rd_addr(r[23:16]);
            rd_addr_2 <= r[5] ? pick_wb_addr(r[15:8]) : pick_rd_addr(r[31:24]);
        end
        wb_idle();

        // debug writes against a busy write-back
        fork
            apb_transfer(1'b1, 7'd5, 32'hdeb0_0005);
            begin
                for (int i = 7; i < 11; i++) begin
                    wb_write(i[6:0], $random(seed));
                end
                wb_idle();
            end
        join
        fork
            apb_transfer(1'b1, 7'd64, 32'h1111_2222);
            begin
                wb_hilo(64'hcafe_0001_beef_0002);
                wb_write(7'd127, 32'h7777_0127);
                wb_idle();
            end
        join
        apb_transfer(1'b0, 7'd5, '0);
        apb_transfer(1'b0, 7'd64, '0);
        apb_transfer(1'b0, 7'd127, '0);
        apb_transfer(1'b0, 7'd7, '0);
        apb_transfer(1'b0, 7'd10, '0);

        // unmapped debug addresses, hi/lo watched on both ports meanwhile
        @(posedge clk);
        rd_addr_1 <= 7'd64;
        rd_addr_2 <= 7'd127;
        apb_transfer(1'b1, 7'd65, 32'hffff_ffff);
        apb_transfer(1'b0, 7'd65, '0);
        apb_transfer(1'b1, 7'd126, 32'h0bad_0bad);
        apb_transfer(1'b0, 7'd100, '0);

        // exception entry, nesting, eret; badvaddr and cause on port 2 and port 1
        @(posedge clk);
        rd_addr_2 <= 7'd40;
        rd_addr_1 <= 7'd45;
        exc_pulse(5'd4, 32'h8000_0100, 32'h0000_1234, 1'b1);
        @(negedge clk);
        check_word("status.exl", status & 32'h2, 32'h2);
        check_word("cause.code", cause & 32'h8000_007c, 32'h8000_0010);
        exc_pulse(5'd12, 32'h9000_0000, 32'h5555_0000, 1'b0);
        @(negedge clk);
        check_word("epc", epc, 32'h8000_0100);
        check_word("cause.code", cause & 32'h8000_007c, 32'h8000_0030);
        eret_pulse();
        @(negedge clk);
        check_word("status.exl", status & 32'h2, 32'h0);

        // interrupt request over hw lines, im and ie
        wb_write(7'd44, 32'h0000_ff01);
        for (int n = 0; n < 80; n++) begin
            r = $random(seed);
            @(posedge clk);
            hw_int <= r[5:0];
            wb_en <= (r[10:8] == 3'd0);
            wb_addr <= r[11] ? 7'd45 : 7'd44;
            wb_data <= $random(seed);
        end
        wb_idle();
        repeat (2) @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: reg_state.f
regs_pkg.sv
reg_wr_if.sv
gpr_hilo_file.sv
cp0_regs.sv
debug_apb_port.sv
reg_wr_arbiter.sv
reg_state_top.sv
tb_reg_state_top.sv
